// ==== hdl/cp0_pkg.sv ====
`default_nettype none

package cp0_pkg;

    // CP0 register map {reg, sel}
    localparam logic [7:0] INDEX    = {5'd0, 3'd0};
    localparam logic [7:0] ENTRYLO0 = {5'd2, 3'd0};
    localparam logic [7:0] ENTRYLO1 = {5'd3, 3'd0};
    localparam logic [7:0] CONTEXT  = {5'd4, 3'd0};
    localparam logic [7:0] BADVADDR = {5'd8, 3'd0};
    localparam logic [7:0] COUNT    = {5'd9, 3'd0};
    localparam logic [7:0] ENTRYHI  = {5'd10, 3'd0};
    localparam logic [7:0] COMPARE  = {5'd11, 3'd0};
    localparam logic [7:0] STATUS   = {5'd12, 3'd0};
    localparam logic [7:0] CAUSE    = {5'd13, 3'd0};
    localparam logic [7:0] EPC      = {5'd14, 3'd0};
    localparam logic [7:0] PRID     = {5'd15, 3'd0};
    localparam logic [7:0] EBASE    = {5'd15, 3'd1};
    localparam logic [7:0] CONFIG   = {5'd16, 3'd0};
    localparam logic [7:0] CONFIG1  = {5'd16, 3'd1};

    localparam logic [4:0] EXC_INT  = 5'd0;
    localparam logic [4:0] EXC_TLBL = 5'd2;
    localparam logic [4:0] EXC_TLBS = 5'd3;
    localparam logic [4:0] EXC_ADEL = 5'd4;
    localparam logic [4:0] EXC_ADES = 5'd5;
    localparam logic [4:0] EXC_SYS  = 5'd8;
    localparam logic [4:0] EXC_BP   = 5'd9;
    localparam logic [4:0] EXC_RI   = 5'd10;

    localparam logic [11:0] VEC_REFILL  = 12'h000;
    localparam logic [11:0] VEC_GENERAL = 12'h180;
    localparam logic [11:0] VEC_IV      = 12'h200;
    localparam logic [31:0] BOOT_BASE   = 32'hBFC0_0200;

    localparam int TLB_ENTRIES = 16;

    typedef struct packed {
        logic        we;
        logic [7:0]  addr;
        logic [31:0] data;
    } cp0_wr_t;

    typedef struct packed {
        logic        valid;
        logic        refill;      // Miss found no entry
        logic [4:0]  code;
        logic [31:0] pc;
        logic        bd;
        logic [31:0] bad_addr;
        logic        badv_we;
    } pipe_exc_t;

    typedef struct packed {
        logic        taken;
        logic [4:0]  code;
        logic [31:0] epc;
        logic        bd;
        logic [31:0] bad_addr;
        logic        badv_we;
        logic        asid_we;
        logic [7:0]  asid;
    } exc_rec_t;

    typedef struct packed {
        logic        user_mode;
        logic        allow_int;
        logic        in_exl;
        logic        boot_exp_vec;
        logic        special_int_vec;
        logic [7:0]  interrupt_mask;
        logic [1:0]  soft_int;
        logic [17:0] ebase;       // EBase bits 29:12
    } cp0_ctl_t;

    typedef struct packed {
        logic [7:0]  asid;
        logic        global;
        logic [18:0] vpn2;
        logic [23:0] pfn1;
        logic        d1;
        logic        v1;
        logic [23:0] pfn0;
        logic        d0;
        logic        v0;
        logic [3:0]  index;
    } tlb_entry_t;

    typedef struct packed {
        logic        hit;
        logic [23:0] pfn;
        logic        valid;
        logic        dirty;
    } xlate_t;

endpackage

`default_nettype wire

// ==== hdl/exc_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module exc_arbiter (
    input  logic               clk,
    input  logic               rst_n,
    input  cp0_pkg::pipe_exc_t pipe_exc_i,
    input  logic [5:0]         hw_int_i,
    input  logic               timer_int_i,
    input  cp0_pkg::cp0_ctl_t  ctl_i,
    input  logic [7:0]         asid_i,
    output cp0_pkg::exc_rec_t  exc_o,
    output logic [31:0]        vector_o
);
    import cp0_pkg::*;

    logic [7:0]  int_pend;
    logic        int_take;
    logic        tlb_class;
    logic        refill_vec;
    logic [31:0] vec_base;
    logic [11:0] vec_off;

    // Same bit order as Cause.IP, timer shares line 5
    assign int_pend = {hw_int_i[5] | timer_int_i, hw_int_i[4:0], ctl_i.soft_int}
                      & ctl_i.interrupt_mask;

    // Synchronous exceptions always win
    assign int_take = (|int_pend) && ctl_i.allow_int && !pipe_exc_i.valid;

    assign tlb_class = (pipe_exc_i.code == EXC_TLBL) || (pipe_exc_i.code == EXC_TLBS);

    always_comb begin
        exc_o.taken    = pipe_exc_i.valid || int_take;
        exc_o.code     = pipe_exc_i.valid ? pipe_exc_i.code : EXC_INT;
        exc_o.epc      = pipe_exc_i.pc;
        exc_o.bd       = pipe_exc_i.bd;
        exc_o.bad_addr = pipe_exc_i.bad_addr;
        exc_o.badv_we  = pipe_exc_i.valid && pipe_exc_i.badv_we;
        exc_o.asid_we  = pipe_exc_i.valid && tlb_class;
        exc_o.asid     = asid_i;
    end

    // Nested misses go through the general vector
    assign refill_vec = pipe_exc_i.valid && pipe_exc_i.refill && !ctl_i.in_exl;

    always_comb begin
        if (ctl_i.boot_exp_vec) begin
            vec_base = BOOT_BASE - 32'h0000_0200;
        end else begin
            vec_base = {2'b10, ctl_i.ebase, 12'h000};
        end

        if (refill_vec) begin
            vec_off = VEC_REFILL;
        end else if (int_take && ctl_i.special_int_vec) begin
            vec_off = VEC_IV;
        end else begin
            vec_off = VEC_GENERAL;
        end
    end

    assign vector_o = vec_base + {20'h0_0000, vec_off};

    a_refill_is_tlb: assert property (
        @(posedge clk) disable iff (!rst_n)
        (pipe_exc_i.valid && pipe_exc_i.refill) |-> tlb_class
    ) else $error("refill report with a non-TLB exception code");

endmodule

`default_nettype wire

// ==== hdl/cp0_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_regs (
    input  logic                clk,
    input  logic                rst_n,
    input  cp0_pkg::cp0_wr_t    wr_i,
    input  logic [7:0]          rd_addr_i,
    input  logic [7:0]          dbg_addr_i,
    output logic [31:0]         rd_data_o,
    output logic [31:0]         dbg_data_o,
    input  logic [5:0]          hw_int_i,
    input  cp0_pkg::exc_rec_t   exc_i,
    input  logic                eret_i,
    input  logic                probe_we_i,
    input  logic [31:0]         probe_i,
    output cp0_pkg::cp0_ctl_t   ctl_o,
    output logic [31:0]         epc_o,
    output logic [7:0]          asid_o,
    output cp0_pkg::tlb_entry_t entry_o,
    output logic                timer_int_o
);
    import cp0_pkg::*;

    logic [31:0] status_q;
    logic        cause_bd_q;
    logic        cause_iv_q;
    logic [1:0]  cause_sw_q;
    logic [4:0]  cause_code_q;
    logic [31:0] count_q;
    logic [31:0] compare_q;
    logic [17:0] ebase_q;
    logic [2:0]  config_k0_q;
    logic        timer_int_q;

    logic [31:0] epc_q;
    logic [31:0] badvaddr_q;
    logic [8:0]  ctx_base_q;      // PTEBase
    logic [18:0] ctx_vpn2_q;
    logic [18:0] ehi_vpn2_q;
    logic [7:0]  ehi_asid_q;
    logic [23:0] elo0_pfn_q;
    logic [2:0]  elo0_dvg_q;
    logic [23:0] elo1_pfn_q;
    logic [2:0]  elo1_dvg_q;
    logic        index_p_q;
    logic [3:0]  index_q;

    function automatic logic [31:0] read_reg(input logic [7:0] addr);
        logic [31:0] val;
        case (addr)
            INDEX:    val = {index_p_q, 27'h0, index_q};
            ENTRYLO0: val = {2'b00, elo0_pfn_q, 3'b000, elo0_dvg_q};
            ENTRYLO1: val = {2'b00, elo1_pfn_q, 3'b000, elo1_dvg_q};
            CONTEXT:  val = {ctx_base_q, ctx_vpn2_q, 4'h0};
            BADVADDR: val = badvaddr_q;
            COUNT:    val = count_q;
            ENTRYHI:  val = {ehi_vpn2_q, 5'h00, ehi_asid_q};
            COMPARE:  val = compare_q;
            STATUS:   val = status_q;
            CAUSE:    val = {cause_bd_q, 7'h00, cause_iv_q, 7'h00, hw_int_i, cause_sw_q,
                             1'b0, cause_code_q, 2'b00};
            EPC:      val = epc_q;
            PRID:     val = 32'h0001_8000;
            EBASE:    val = {2'b10, ebase_q, 12'h000};
            CONFIG:   val = {1'b1, 21'h0, 3'd1, 4'h0, config_k0_q};  // MT=TLB
            CONFIG1:  val = {1'b0, 6'd15, 3'd0, 3'd3, 3'd0, 3'd0, 3'd3, 3'd0, 7'd0};
            default:  val = 32'h0;
        endcase
        return val;
    endfunction

    always_comb begin
        rd_data_o  = rst_n ? read_reg(rd_addr_i) : 32'h0;
        dbg_data_o = rst_n ? read_reg(dbg_addr_i) : 32'h0;
    end

    // Control registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_q     <= 32'h1040_0004;  // BEV and ERL set
            cause_bd_q   <= 1'b0;
            cause_iv_q   <= 1'b0;
            cause_sw_q   <= 2'b00;
            cause_code_q <= 5'h00;
            count_q      <= 32'h0;
            compare_q    <= 32'h0;
            ebase_q      <= 18'h0;
            config_k0_q  <= 3'd2;           // Uncached kseg0
            timer_int_q  <= 1'b0;
        end else begin
            count_q <= count_q + 32'd1;
            if (compare_q != 32'h0 && compare_q == count_q) begin
                timer_int_q <= 1'b1;
            end
            if (wr_i.we) begin
                case (wr_i.addr)
                    COMPARE: begin
                        compare_q   <= wr_i.data;
                        timer_int_q <= 1'b0;  // Acknowledge
                    end
                    COUNT:  count_q <= wr_i.data;
                    EBASE:  ebase_q <= wr_i.data[29:12];
                    CAUSE: begin
                        cause_iv_q <= wr_i.data[23];
                        cause_sw_q <= wr_i.data[9:8];
                    end
                    STATUS: begin
                        status_q[28]   <= wr_i.data[28];    // CU0
                        status_q[22]   <= wr_i.data[22];    // BEV
                        status_q[15:8] <= wr_i.data[15:8];  // IM
                        status_q[4]    <= wr_i.data[4];     // UM
                        status_q[2:0]  <= wr_i.data[2:0];   // ERL EXL IE
                    end
                    CONFIG: config_k0_q <= wr_i.data[2:0];
                    default: ;
                endcase
            end
            if (exc_i.taken) begin
                status_q[1]  <= 1'b1;
                cause_bd_q   <= exc_i.bd;
                cause_code_q <= exc_i.code;
            end
            if (eret_i) begin
                status_q[1] <= 1'b0;
            end
        end
    end

    // Payload registers, later assignments take priority
    always_ff @(posedge clk) begin
        if (wr_i.we) begin
            case (wr_i.addr)
                EPC: epc_q <= wr_i.data;
                ENTRYHI: begin
                    ehi_vpn2_q <= wr_i.data[31:13];
                    ehi_asid_q <= wr_i.data[7:0];
                end
                ENTRYLO0: begin
                    elo0_pfn_q <= wr_i.data[29:6];
                    elo0_dvg_q <= wr_i.data[2:0];
                end
                ENTRYLO1: begin
                    elo1_pfn_q <= wr_i.data[29:6];
                    elo1_dvg_q <= wr_i.data[2:0];
                end
                INDEX:   index_q    <= wr_i.data[3:0];
                CONTEXT: ctx_base_q <= wr_i.data[31:23];
                default: ;
            endcase
        end
        if (probe_we_i) begin
            index_p_q <= probe_i[31];
            index_q   <= probe_i[3:0];
        end
        if (exc_i.taken) begin
            if (exc_i.badv_we) begin
                badvaddr_q <= exc_i.bad_addr;
            end
            ctx_vpn2_q <= exc_i.bad_addr[31:13];
            ehi_vpn2_q <= exc_i.bad_addr[31:13];
            if (exc_i.asid_we) begin
                ehi_asid_q <= exc_i.asid;
            end
            epc_q <= exc_i.epc;
        end
    end

    always_comb begin
        ctl_o.user_mode       = status_q[4:1] == 4'b1000;
        ctl_o.allow_int       = status_q[2:0] == 3'b001;
        ctl_o.in_exl          = status_q[1];
        ctl_o.boot_exp_vec    = status_q[22];
        ctl_o.special_int_vec = cause_iv_q;
        ctl_o.interrupt_mask  = status_q[15:8];
        ctl_o.soft_int        = cause_sw_q;
        ctl_o.ebase           = ebase_q;
    end

    assign epc_o       = epc_q;
    assign asid_o      = ehi_asid_q;
    assign timer_int_o = timer_int_q;

    always_comb begin
        entry_o.asid   = ehi_asid_q;
        entry_o.global = elo1_dvg_q[0] & elo0_dvg_q[0];  // G needs both halves
        entry_o.vpn2   = ehi_vpn2_q;
        entry_o.pfn1   = elo1_pfn_q;
        entry_o.d1     = elo1_dvg_q[2];
        entry_o.v1     = elo1_dvg_q[1];
        entry_o.pfn0   = elo0_pfn_q;
        entry_o.d0     = elo0_dvg_q[2];
        entry_o.v0     = elo0_dvg_q[1];
        entry_o.index  = index_q;
    end

    a_no_exc_with_eret: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(exc_i.taken && eret_i)
    ) else $error("exception capture and eret in the same cycle");

endmodule

`default_nettype wire

// ==== hdl/tlb_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module tlb_array (
    input  logic                clk,
    input  logic                rst_n,
    input  cp0_pkg::tlb_entry_t entry_i,
    input  logic [7:0]          asid_i,
    input  logic                tlbwi_i,
    input  logic                tlbp_i,
    output logic [31:0]         probe_o,
    output logic                probe_we_o,
    input  logic [31:0]         vaddr_i,
    output cp0_pkg::xlate_t     xlate_o
);
    import cp0_pkg::*;

    logic [18:0] vpn2_q [TLB_ENTRIES];
    logic [7:0]  asid_q [TLB_ENTRIES];
    logic        g_q    [TLB_ENTRIES];
    logic [23:0] pfn0_q [TLB_ENTRIES];
    logic [23:0] pfn1_q [TLB_ENTRIES];
    logic [1:0]  dv0_q  [TLB_ENTRIES];
    logic [1:0]  dv1_q  [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] filled_q;  // Entry holds a written mapping

    logic        probe_hit;
    logic [3:0]  probe_idx;
    logic        xl_hit;
    logic [3:0]  xl_idx;

    function automatic logic entry_match(input int i, input logic [18:0] vpn2,
                                         input logic [7:0] asid);
        return filled_q[i] && (vpn2_q[i] == vpn2) && (g_q[i] || asid_q[i] == asid);
    endfunction

    always_ff @(posedge clk) begin
        if (tlbwi_i) begin
            vpn2_q[entry_i.index] <= entry_i.vpn2;
            asid_q[entry_i.index] <= entry_i.asid;
            g_q[entry_i.index]    <= entry_i.global;
            pfn0_q[entry_i.index] <= entry_i.pfn0;
            pfn1_q[entry_i.index] <= entry_i.pfn1;
            dv0_q[entry_i.index]  <= {entry_i.d0, entry_i.v0};
            dv1_q[entry_i.index]  <= {entry_i.d1, entry_i.v1};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            filled_q <= '0;
        end else if (tlbwi_i) begin
            filled_q[entry_i.index] <= 1'b1;
        end
    end

    // Lowest index wins on a multiple match
    always_comb begin
        probe_hit = 1'b0;
        probe_idx = 4'h0;
        xl_hit    = 1'b0;
        xl_idx    = 4'h0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (entry_match(i, entry_i.vpn2, entry_i.asid)) begin
                probe_hit = 1'b1;
                probe_idx = 4'(i);
            end
            if (entry_match(i, vaddr_i[31:13], asid_i)) begin
                xl_hit = 1'b1;
                xl_idx = 4'(i);
            end
        end
    end

    assign probe_o    = {~probe_hit, 27'h0, probe_idx};
    assign probe_we_o = tlbp_i;

    always_comb begin
        xlate_o.hit = xl_hit;
        if (!xl_hit) begin
            xlate_o.pfn   = 24'h0;
            xlate_o.valid = 1'b0;
            xlate_o.dirty = 1'b0;
        end else if (vaddr_i[12]) begin
            xlate_o.pfn   = pfn1_q[xl_idx];
            xlate_o.valid = dv1_q[xl_idx][0];
            xlate_o.dirty = dv1_q[xl_idx][1];
        end else begin
            xlate_o.pfn   = pfn0_q[xl_idx];
            xlate_o.valid = dv0_q[xl_idx][0];
            xlate_o.dirty = dv0_q[xl_idx][1];
        end
    end

    a_no_write_with_probe: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(tlbwi_i && tlbp_i)
    ) else $error("tlbwi and tlbp issued together");

endmodule

`default_nettype wire

// ==== hdl/cp0_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_top (
    input  logic               clk,
    input  logic               rst_n,
    input  cp0_pkg::cp0_wr_t   cp0_wr_i,
    input  logic [7:0]         rd_addr_i,
    output logic [31:0]        rd_data_o,
    input  logic [7:0]         dbg_addr_i,
    output logic [31:0]        dbg_data_o,
    input  logic [5:0]         hw_int_i,
    input  cp0_pkg::pipe_exc_t pipe_exc_i,
    input  logic               eret_i,
    input  logic               tlbwi_i,
    input  logic               tlbp_i,
    input  logic [31:0]        vaddr_i,
    output logic               exc_taken_o,
    output logic [31:0]        exc_vector_o,
    output logic [31:0]        epc_o,
    output logic               user_mode_o,
    output cp0_pkg::xlate_t    xlate_o
);
    import cp0_pkg::*;

    exc_rec_t   exc_rec;
    cp0_ctl_t   ctl;
    tlb_entry_t entry;
    logic       timer_int;
    logic [7:0] asid;
    logic [31:0] probe;
    logic       probe_we;

    exc_arbiter u_arb (
        .clk         (clk),
        .rst_n       (rst_n),
        .pipe_exc_i  (pipe_exc_i),
        .hw_int_i    (hw_int_i),
        .timer_int_i (timer_int),
        .ctl_i       (ctl),
        .asid_i      (asid),
        .exc_o       (exc_rec),
        .vector_o    (exc_vector_o)
    );

    cp0_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_i        (cp0_wr_i),
        .rd_addr_i   (rd_addr_i),
        .dbg_addr_i  (dbg_addr_i),
        .rd_data_o   (rd_data_o),
        .dbg_data_o  (dbg_data_o),
        .hw_int_i    (hw_int_i),
        .exc_i       (exc_rec),
        .eret_i      (eret_i),
        .probe_we_i  (probe_we),
        .probe_i     (probe),
        .ctl_o       (ctl),
        .epc_o       (epc_o),
        .asid_o      (asid),
        .entry_o     (entry),
        .timer_int_o (timer_int)
    );

    tlb_array u_tlb (
        .clk        (clk),
        .rst_n      (rst_n),
        .entry_i    (entry),
        .asid_i     (asid),
        .tlbwi_i    (tlbwi_i),
        .tlbp_i     (tlbp_i),
        .probe_o    (probe),
        .probe_we_o (probe_we),
        .vaddr_i    (vaddr_i),
        .xlate_o    (xlate_o)
    );

    assign exc_taken_o = exc_rec.taken;
    assign user_mode_o = ctl.user_mode;

endmodule

`default_nettype wire

// ==== testbench/tb_cp0_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cp0_top;
    import cp0_pkg::*;

    localparam logic [31:0] STATUS_MASK = 32'h1040_FF17;
    localparam int MAX_CYCLES = 4000;  // Whole run needs well under 1500 cycles

    logic clk;
    logic rst_n;
    cp0_wr_t cp0_wr;
    logic [7:0] rd_addr;
    logic [7:0] dbg_addr;
    logic [31:0] rd_data;
    logic [31:0] dbg_data;
    logic [5:0] hw_int;
    pipe_exc_t pipe_exc;
    logic eret;
    logic tlbwi;
    logic tlbp;
    logic [31:0] vaddr;
    logic exc_taken;
    logic [31:0] exc_vector;
    logic [31:0] epc;
    logic user_mode;
    xlate_t xlate;

    int errors;
    int cycles;
    logic [31:0] seed;

    // Shadow of the register file
    logic [31:0] sh_status;
    logic sh_bd, sh_iv;
    logic [1:0] sh_sw;
    logic [4:0] sh_code;
    logic [31:0] sh_epc, sh_badv, sh_compare, sh_elo0, sh_elo1;
    logic [8:0] sh_ctx_base;
    logic [18:0] sh_ctx_vpn2, sh_ehi_vpn2;
    logic [7:0] sh_ehi_asid;
    logic [17:0] sh_ebase;
    logic [2:0] sh_k0;
    logic sh_index_p;
    logic [3:0] sh_index;

    // Shadow TLB
    logic [18:0] t_vpn2 [16];
    logic [7:0] t_asid [16];
    logic t_g [16];
    logic [23:0] t_pfn0 [16];
    logic [23:0] t_pfn1 [16];
    logic [1:0] t_dv0 [16];
    logic [1:0] t_dv1 [16];
    logic t_filled [16];

    cp0_top UUT (
        .clk(clk), .rst_n(rst_n), .cp0_wr_i(cp0_wr),
        .rd_addr_i(rd_addr), .rd_data_o(rd_data),
        .dbg_addr_i(dbg_addr), .dbg_data_o(dbg_data),
        .hw_int_i(hw_int), .pipe_exc_i(pipe_exc), .eret_i(eret),
        .tlbwi_i(tlbwi), .tlbp_i(tlbp), .vaddr_i(vaddr),
        .exc_taken_o(exc_taken), .exc_vector_o(exc_vector), .epc_o(epc),
        .user_mode_o(user_mode), .xlate_o(xlate)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors: %0d", errors + 1);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] rand32();
        seed = seed * 32'd1664525 + 32'd1013904223;  // LCG step
        return seed;
    endfunction

    function automatic logic [31:0] expected_read(input logic [7:0] addr);
        case (addr)
            INDEX:    return {sh_index_p, 27'h0, sh_index};
            ENTRYLO0: return sh_elo0;
            ENTRYLO1: return sh_elo1;
            CONTEXT:  return {sh_ctx_base, sh_ctx_vpn2, 4'h0};
            BADVADDR: return sh_badv;
            ENTRYHI:  return {sh_ehi_vpn2, 5'h00, sh_ehi_asid};
            COMPARE:  return sh_compare;
            STATUS:   return sh_status;
            CAUSE:    return {sh_bd, 7'h00, sh_iv, 7'h00, hw_int, sh_sw, 1'b0, sh_code, 2'b00};
            EPC:      return sh_epc;
            PRID:     return 32'h0001_8000;
            EBASE:    return {2'b10, sh_ebase, 12'h000};
            CONFIG:   return 32'h8000_0080 | {29'h0, sh_k0};
            CONFIG1:  return 32'h1E18_0C00;
            default:  return 32'h0;
        endcase
    endfunction

    function automatic logic is_user_mode(input logic [31:0] status);
        return status[4] && !status[2] && !status[1];  // UM with EXL and ERL clear
    endfunction

    function automatic logic [31:0] expected_vector(input logic refill, input logic is_int);
        logic [31:0] base;
        logic [11:0] off;
        base = sh_status[22] ? 32'hBFC0_0000 : {2'b10, sh_ebase, 12'h000};
        if (refill && !sh_status[1]) off = 12'h000;
        else if (is_int && sh_iv) off = 12'h200;
        else off = 12'h180;
        return base + {20'h0, off};
    endfunction

    function automatic logic [31:0] expected_probe(input logic [18:0] vpn2, input logic [7:0] asid);
        for (int i = 0; i < 16; i++) begin
            if (t_filled[i] && t_vpn2[i] == vpn2 && (t_g[i] || t_asid[i] == asid))
                return {1'b0, 27'h0, 4'(i)};
        end
        return 32'h8000_0000;
    endfunction

    function automatic logic [31:0] expected_xlate(input logic [31:0] va, input logic [7:0] asid);
        for (int i = 0; i < 16; i++) begin
            if (t_filled[i] && t_vpn2[i] == va[31:13] && (t_g[i] || t_asid[i] == asid)) begin
                if (va[12]) return {5'h0, 1'b1, t_pfn1[i], t_dv1[i][0], t_dv1[i][1]};
                return {5'h0, 1'b1, t_pfn0[i], t_dv0[i][0], t_dv0[i][1]};
            end
        end
        return 32'h0;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        cp0_wr <= {1'b1, addr, data};
        @(posedge clk);
        cp0_wr <= '0;
        case (addr)
            STATUS:   sh_status = (sh_status & ~STATUS_MASK) | (data & STATUS_MASK);
            CAUSE: begin
                sh_iv = data[23];
                sh_sw = data[9:8];
            end
            EBASE:    sh_ebase = data[29:12];
            CONFIG:   sh_k0 = data[2:0];
            COMPARE:  sh_compare = data;
            EPC:      sh_epc = data;
            ENTRYHI: begin
                sh_ehi_vpn2 = data[31:13];
                sh_ehi_asid = data[7:0];
            end
            ENTRYLO0: sh_elo0 = data & 32'h3FFF_FFC7;
            ENTRYLO1: sh_elo1 = data & 32'h3FFF_FFC7;
            INDEX:    sh_index = data[3:0];
            CONTEXT:  sh_ctx_base = data[31:23];
            default: ;
        endcase
    endtask

    task automatic read_check(input string name, input logic [7:0] addr, input logic [31:0] mask);
        @(posedge clk);
        rd_addr <= addr;
        dbg_addr <= addr;
        @(negedge clk);
        check(name, expected_read(addr) & mask, rd_data & mask);
        check({name, " dbg"}, expected_read(addr) & mask, dbg_data & mask);
        check({name, " user mode"}, {31'h0, is_user_mode(sh_status)}, {31'h0, user_mode});
    endtask

    task automatic capture_shadow(input logic [4:0] code, input logic [31:0] pc, input logic bd,
                                  input logic [31:0] bad, input logic badv_we);
        sh_status[1] = 1'b1;
        sh_bd = bd;
        sh_code = code;
        sh_epc = pc;
        if (badv_we) sh_badv = bad;
        sh_ctx_vpn2 = bad[31:13];
        sh_ehi_vpn2 = bad[31:13];
    endtask

    task automatic raise_exc(input string name, input logic [4:0] code, input logic refill,
                             input logic bd, input logic [31:0] bad, input logic badv_we,
                             input logic [5:0] hw);
        pipe_exc_t pe;
        pe = '0;
        pe.valid = 1'b1;
        pe.refill = refill;
        pe.code = code;
        pe.pc = rand32() & 32'hFFFF_FFFC;
        pe.bd = bd;
        pe.bad_addr = bad;
        pe.badv_we = badv_we;
        @(posedge clk);
        pipe_exc <= pe;
        hw_int <= hw;
        @(negedge clk);
        check({name, " taken"}, 32'd1, {31'h0, exc_taken});
        check({name, " vector"}, expected_vector(refill, 1'b0), exc_vector);
        @(posedge clk);
        pipe_exc <= '0;
        hw_int <= '0;
        capture_shadow(code, pe.pc, bd, bad, badv_we);
        read_check({name, " epc"}, EPC, 32'hFFFF_FFFF);
        check({name, " epc out"}, sh_epc, epc);
        read_check({name, " cause"}, CAUSE, 32'hFFFF_FFFF);
        read_check({name, " badvaddr"}, BADVADDR, 32'hFFFF_FFFF);
        read_check({name, " context"}, CONTEXT, 32'hFFFF_FFFF);
        read_check({name, " status"}, STATUS, 32'hFFFF_FFFF);
        read_check({name, " entryhi"}, ENTRYHI, 32'hFFFF_FFFF);
    endtask

    task automatic do_eret();
        @(posedge clk);
        eret <= 1'b1;
        @(posedge clk);
        eret <= 1'b0;
        sh_status[1] = 1'b0;
        read_check("eret status", STATUS, 32'hFFFF_FFFF);
    endtask

    task automatic expect_quiet(input string name, input int n);
        repeat (n) begin
            @(negedge clk);
            check(name, 32'd0, {31'h0, exc_taken});
        end
    endtask

    task automatic stage_entry(input int i);
        logic [31:0] r;
        logic g;
        r = rand32();
        g = (i % 3 == 0);
        t_vpn2[i] = {r[30:16], 4'(i)};
        t_asid[i] = r[7:0] & 8'h03;
        t_g[i] = g;
        t_pfn0[i] = rand32() & 24'hFF_FFFF;
        t_pfn1[i] = rand32() & 24'hFF_FFFF;
        r = rand32();
        t_dv0[i] = r[1:0];
        t_dv1[i] = r[3:2];
        write_reg(ENTRYHI, {t_vpn2[i], 5'h0, t_asid[i]});
        write_reg(ENTRYLO0, {2'b00, t_pfn0[i], 3'b000, t_dv0[i], g});
        write_reg(ENTRYLO1, {2'b00, t_pfn1[i], 3'b000, t_dv1[i], g});
        write_reg(INDEX, 32'(i));
        @(posedge clk);
        tlbwi <= 1'b1;
        @(posedge clk);
        tlbwi <= 1'b0;
        t_filled[i] = 1'b1;
    endtask

    initial begin
        logic [7:0] regs [11];
        logic [31:0] d;
        logic [31:0] c;
        logic [18:0] vpn2;
        logic [7:0] asid;
        int waited;

        errors = 0;
        cycles = 0;
        seed = 32'h96db_765b;
        rst_n = 1'b0;
        cp0_wr = '0;
        rd_addr = 8'h0;
        dbg_addr = 8'h0;
        hw_int = 6'h0;
        pipe_exc = '0;
        eret = 1'b0;
        tlbwi = 1'b0;
        tlbp = 1'b0;
        vaddr = 32'h0;
        sh_status = 32'h1040_0004;
        {sh_bd, sh_iv, sh_sw, sh_code} = '0;
        {sh_epc, sh_badv, sh_compare, sh_elo0, sh_elo1} = '0;
        {sh_ctx_base, sh_ctx_vpn2, sh_ehi_vpn2, sh_ehi_asid} = '0;
        sh_ebase = 18'h0;
        sh_k0 = 3'd2;
        sh_index_p = 1'b0;
        sh_index = 4'h0;
        for (int i = 0; i < 16; i++) t_filled[i] = 1'b0;
        regs = '{ENTRYLO0, ENTRYLO1, CONTEXT, ENTRYHI, COMPARE, STATUS, CAUSE, EPC, EBASE,
                 CONFIG, INDEX};
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        read_check("reset status", STATUS, 32'hFFFF_FFFF);
        read_check("reset ebase", EBASE, 32'hFFFF_FFFF);
        read_check("reset prid", PRID, 32'hFFFF_FFFF);
        read_check("reset config", CONFIG, 32'hFFFF_FFFF);
        read_check("reset config1", CONFIG1, 32'hFFFF_FFFF);
        check("reset taken", 32'd0, {31'h0, exc_taken});

        for (int round = 0; round < 4; round++) begin
            foreach (regs[k]) begin
                d = rand32();
                if (regs[k] == STATUS) d[0] = 1'b0;  // Keep interrupts off
                write_reg(regs[k], d);
                if (regs[k] == INDEX) read_check("write index", INDEX, 32'h0000_000F);
                else if (regs[k] == CONTEXT) read_check("write context", CONTEXT, 32'hFF80_0000);
                else read_check("write reg", regs[k], 32'hFFFF_FFFF);
            end
        end
        d = rand32();
        write_reg(COUNT, d);
        @(posedge clk);
        rd_addr <= COUNT;
        @(negedge clk);
        check("write count", d + 32'd1, rd_data);
        write_reg(COMPARE, 32'h0);
        write_reg(CAUSE, 32'h0);

        // Synchronous exceptions
        write_reg(STATUS, 32'h1040_0010);
        raise_exc("bev adel", EXC_ADEL, 1'b0, 1'b1, rand32(), 1'b1, 6'h0);
        do_eret();
        raise_exc("bev sys", EXC_SYS, 1'b0, 1'b0, rand32(), 1'b0, 6'h0);
        do_eret();
        write_reg(EBASE, rand32());
        write_reg(STATUS, 32'h1000_0000);
        raise_exc("refill", EXC_TLBL, 1'b1, 1'b0, rand32(), 1'b1, 6'h0);
        raise_exc("nested refill", EXC_TLBS, 1'b1, 1'b1, rand32(), 1'b1, 6'h0);
        do_eret();
        write_reg(STATUS, 32'h1000_0401);
        write_reg(CAUSE, 32'h0080_0000);
        raise_exc("sync over int", EXC_RI, 1'b0, 1'b0, rand32(), 1'b0, 6'h01);
        do_eret();

        // Software interrupts
        write_reg(STATUS, 32'h1000_0201);
        write_reg(CAUSE, 32'h0080_0100);
        expect_quiet("masked soft int", 6);
        write_reg(CAUSE, 32'h0080_0300);
        @(negedge clk);
        check("soft int taken", 32'd1, {31'h0, exc_taken});
        check("soft int vector", expected_vector(1'b0, 1'b1), exc_vector);
        capture_shadow(EXC_INT, 32'h0, 1'b0, 32'h0, 1'b0);
        write_reg(CAUSE, 32'h0080_0000);
        read_check("soft int cause", CAUSE, 32'hFFFF_FFFF);
        do_eret();

        // Timer through line 5
        write_reg(STATUS, 32'h1000_8001);
        @(posedge clk);
        rd_addr <= COUNT;
        @(negedge clk);
        c = rd_data;
        write_reg(COMPARE, c + 32'd50);
        waited = 0;
        while (!exc_taken && waited < 60) begin
            @(negedge clk);
            waited++;
        end
        if (!exc_taken) begin
            errors++;
            $display("Timer interrupt was not taken within 60 cycles of the Compare write");
        end else begin
            check("timer vector", expected_vector(1'b0, 1'b1), exc_vector);
            @(posedge clk);
            capture_shadow(EXC_INT, 32'h0, 1'b0, 32'h0, 1'b0);
            read_check("timer cause", CAUSE, 32'hFFFF_FFFF);
        end
        write_reg(COMPARE, 32'h0);
        do_eret();
        expect_quiet("timer cleared", 6);
        write_reg(STATUS, 32'h1000_0000);

        // TLB write, probe, translate
        for (int i = 0; i < 10; i++) stage_entry(i);
        for (int k = 0; k < 16; k++) begin
            vpn2 = (k < 10) ? t_vpn2[k] : 19'(rand32());
            asid = (k < 10 && !t_g[k]) ? t_asid[k] : 8'(rand32() & 32'h3);
            write_reg(ENTRYHI, {vpn2, 5'h0, asid});
            @(posedge clk);
            tlbp <= 1'b1;
            @(posedge clk);
            tlbp <= 1'b0;
            d = expected_probe(vpn2, asid);
            sh_index_p = d[31];
            sh_index = d[3:0];
            read_check("probe index", INDEX, 32'hFFFF_FFFF);
        end
        for (int k = 0; k < 40; k++) begin
            d = rand32();
            vpn2 = d[0] ? t_vpn2[d[7:4] % 10] : 19'(rand32());
            asid = 8'(rand32() & 32'h3);
            write_reg(ENTRYHI, {19'(rand32()), 5'h0, asid});
            c = {vpn2, 13'(rand32())};
            @(posedge clk);
            vaddr <= c;
            @(negedge clk);
            check("xlate", expected_xlate(c, asid), {5'h0, xlate});
        end

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
hdl/cp0_pkg.sv
hdl/exc_arbiter.sv
hdl/cp0_regs.sv
hdl/tlb_array.sv
hdl/cp0_top.sv
testbench/tb_cp0_top.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CP0 testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_cp0_top -o sim_cp0
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_cp0)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "ALL CHECKS PASSED"; then
    exit 0
fi
exit 1
